// ==== flist.f ====
src/legv8Pkg.sv
src/registerFile.sv
src/dataMemory.sv
src/decodeStage.sv
src/executeStage.sv
src/memAccessStage.sv
src/datapathWithMemory.sv
testbench/datapathTb.sv

// ==== src/dataMemory.sv ====
`default_nettype none

module dataMemory #(
	// Power of two, at least 8
	parameter int memDepthBytes = 256
) (
	input  wire logic              clock,
	input  wire logic              arstN,
	input  wire logic              writeEn,
	input  wire logic [63:0]       writeAddr,
	input  wire legv8Pkg::memSizeE writeSize,
	input  wire logic [63:0]       writeData,
	input  wire logic [63:0]       readAddr,
	input  wire legv8Pkg::memSizeE readSize,
	output logic [63:0]            readData
);

	localparam int addrW = $clog2(memDepthBytes);

	logic [7:0]       memBytes [memDepthBytes];
	logic [addrW-1:0] writeBase;
	logic [addrW-1:0] readBase;

	// Clear low bits to size alignment, wrap to depth
	function automatic logic [addrW-1:0] alignIndex(input logic [63:0] addr,
		input legv8Pkg::memSizeE size);
		logic [63:0] mask;
		mask = ~((64'd1 << size) - 64'd1);
		return addrW'(addr & mask);
	endfunction

	function automatic int byteCount(input legv8Pkg::memSizeE size);
		return 1 << size;
	endfunction

	assign writeBase = alignIndex(writeAddr, writeSize);
	assign readBase  = alignIndex(readAddr, readSize);

	// Little endian, low bytes of writeData only
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < memDepthBytes; i++) begin
				memBytes[i] <= '0;
			end
		end else if (writeEn) begin
			for (int i = 0; i < 8; i++) begin
				if (i < byteCount(writeSize)) begin
					memBytes[writeBase + addrW'(i)] <= writeData[8*i +: 8];
				end
			end
		end
	end

	// Zero-extended combinational load
	always_comb begin
		readData = '0;
		for (int i = 0; i < 8; i++) begin
			if (i < byteCount(readSize)) begin
				readData[8*i +: 8] = memBytes[readBase + addrW'(i)];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/datapathWithMemory.sv ====
`default_nettype none

module datapathWithMemory #(
	parameter int memDepthBytes = 256
) (
	input  wire logic        clock,
	input  wire logic        arstN,
	input  wire logic        cwValid,
	output logic             cwReady,
	input  wire logic [31:0] controlWord,
	input  wire logic [63:0] constant,
	output logic             resultValid,
	input  wire logic        resultReady,
	output logic [63:0]      result,
	output legv8Pkg::statusT status
);

	// Register file ports
	logic [4:0]  readAddrA;
	logic [4:0]  readAddrB;
	logic [63:0] readDataA;
	logic [63:0] readDataB;
	logic        rfWriteEn;
	logic [4:0]  rfWriteAddr;
	logic [63:0] rfWriteData;

	// Decode to execute
	logic              decValid;
	legv8Pkg::aluOpE   aluOp;
	logic              carryIn;
	logic [63:0]       opA;
	logic [63:0]       opB;
	logic [63:0]       storeData;
	logic [4:0]        destReg;
	logic              regWrite;
	logic              memEnable;
	logic              memWrite;
	legv8Pkg::memSizeE memSize;
	logic              exUpReady;

	// Execute to memory
	logic              exValid;
	logic [4:0]        exDestReg;
	logic              exRegWrite;
	logic [63:0]       aluResult;
	legv8Pkg::statusT  aluStatus;
	logic [63:0]       exStoreData;
	logic              exMemEnable;
	logic              exMemWrite;
	legv8Pkg::memSizeE exMemSize;
	logic              memUpReady;

	// Memory stage entry, for hazard checks
	logic       memValid;
	logic [4:0] memDestReg;
	logic       memRegWrite;

	registerFile u_registerFile (
		.clock, .arstN, .readAddrA, .readAddrB,
		.writeEn(rfWriteEn), .writeAddr(rfWriteAddr), .writeData(rfWriteData),
		.readDataA, .readDataB
	);

	decodeStage u_decodeStage (
		.clock, .arstN, .cwValid, .controlWord, .constant, .readDataA, .readDataB,
		.exBusy(exValid), .exDestReg, .exRegWrite, .memDestReg, .memRegWrite, .memValid,
		.downReady(exUpReady), .cwReady, .readAddrA, .readAddrB, .decValid, .aluOp,
		.carryIn, .opA, .opB, .storeData, .destReg, .regWrite, .memEnable, .memWrite,
		.memSize
	);

	executeStage u_executeStage (
		.clock, .arstN, .decValid, .aluOp, .carryIn, .opA, .opB, .storeData, .destReg,
		.regWrite, .memEnable, .memWrite, .memSize, .downReady(memUpReady),
		.upReady(exUpReady), .exValid, .exDestReg, .exRegWrite, .aluResult, .aluStatus,
		.exStoreData, .exMemEnable, .exMemWrite, .exMemSize
	);

	memAccessStage #(
		.memDepthBytes(memDepthBytes)
	) u_memAccessStage (
		.clock, .arstN, .exValid, .exDestReg, .exRegWrite, .aluResult, .aluStatus,
		.exStoreData, .exMemEnable, .exMemWrite, .exMemSize, .resultReady,
		.upReady(memUpReady), .resultValid, .result, .status, .memValid, .memDestReg,
		.memRegWrite, .writeEn(rfWriteEn), .writeAddr(rfWriteAddr), .writeData(rfWriteData)
	);

endmodule

`default_nettype wire

// ==== src/decodeStage.sv ====
`default_nettype none

module decodeStage (
	input  wire logic              clock,
	input  wire logic              arstN,
	input  wire logic              cwValid,
	input  wire logic [31:0]       controlWord,
	input  wire logic [63:0]       constant,
	input  wire logic [63:0]       readDataA,
	input  wire logic [63:0]       readDataB,
	input  wire logic              exBusy,
	input  wire logic [4:0]        exDestReg,
	input  wire logic              exRegWrite,
	input  wire logic [4:0]        memDestReg,
	input  wire logic              memRegWrite,
	input  wire logic              memValid,
	input  wire logic              downReady,
	output logic                   cwReady,
	output logic [4:0]             readAddrA,
	output logic [4:0]             readAddrB,
	output logic                   decValid,
	output legv8Pkg::aluOpE        aluOp,
	output logic                   carryIn,
	output logic [63:0]            opA,
	output logic [63:0]            opB,
	output logic [63:0]            storeData,
	output logic [4:0]             destReg,
	output logic                   regWrite,
	output logic                   memEnable,
	output logic                   memWrite,
	output legv8Pkg::memSizeE      memSize
);

	logic bsel;
	logic storeOp;
	logic useB;
	logic hazardA;
	logic hazardB;
	logic accept;

	// Pending write of src in one stage
	function automatic logic regMatch(input logic [4:0] src, input logic busy,
		input logic wr, input logic [4:0] dst);
		return busy && wr && (src == dst) && (src != legv8Pkg::zeroReg);
	endfunction

	// Field split
	assign readAddrA = controlWord[legv8Pkg::saLo +: 5];
	assign readAddrB = controlWord[legv8Pkg::sbLo +: 5];
	assign bsel      = controlWord[legv8Pkg::bselBit];
	assign storeOp   = controlWord[legv8Pkg::memEnBit] && controlWord[legv8Pkg::memWrBit];

	// SB is read for register B or as store data
	assign useB = !bsel || controlWord[legv8Pkg::memWrBit];

	// RAW check against all three pipeline entries
	assign hazardA = regMatch(readAddrA, decValid, regWrite, destReg)
		|| regMatch(readAddrA, exBusy, exRegWrite, exDestReg)
		|| regMatch(readAddrA, memValid, memRegWrite, memDestReg);
	assign hazardB = useB && (regMatch(readAddrB, decValid, regWrite, destReg)
		|| regMatch(readAddrB, exBusy, exRegWrite, exDestReg)
		|| regMatch(readAddrB, memValid, memRegWrite, memDestReg));

	assign cwReady = !(hazardA || hazardB) && (!decValid || downReady);
	assign accept  = cwValid && cwReady;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
		end else if (!decValid || downReady) begin
			decValid <= accept;
		end
	end

	// Payload, loaded on acceptance only
	always_ff @(posedge clock) begin
		if (accept) begin
			aluOp     <= legv8Pkg::aluOpE'(controlWord[legv8Pkg::fsLo +: 5]);
			carryIn   <= controlWord[legv8Pkg::c0Bit];
			opA       <= readDataA;
			// Bsel picks the constant
			opB       <= bsel ? constant : readDataB;
			storeData <= readDataB;
			destReg   <= controlWord[legv8Pkg::daLo +: 5];
			regWrite  <= controlWord[legv8Pkg::regWrBit];
			memEnable <= controlWord[legv8Pkg::memEnBit];
			memWrite  <= storeOp;
			memSize   <= legv8Pkg::memSizeE'(controlWord[legv8Pkg::sizeLo +: 2]);
		end
	end

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
`default_nettype none

module executeStage (
	input  wire logic              clock,
	input  wire logic              arstN,
	input  wire logic              decValid,
	input  wire legv8Pkg::aluOpE   aluOp,
	input  wire logic              carryIn,
	input  wire logic [63:0]       opA,
	input  wire logic [63:0]       opB,
	input  wire logic [63:0]       storeData,
	input  wire logic [4:0]        destReg,
	input  wire logic              regWrite,
	input  wire logic              memEnable,
	input  wire logic              memWrite,
	input  wire legv8Pkg::memSizeE memSize,
	input  wire logic              downReady,
	output logic                   upReady,
	output logic                   exValid,
	output logic [4:0]             exDestReg,
	output logic                   exRegWrite,
	output logic [63:0]            aluResult,
	output legv8Pkg::statusT       aluStatus,
	output logic [63:0]            exStoreData,
	output logic                   exMemEnable,
	output logic                   exMemWrite,
	output legv8Pkg::memSizeE      exMemSize
);

	logic [64:0]      sum;
	logic [63:0]      addB;
	logic             addCin;
	logic [63:0]      aluOut;
	legv8Pkg::statusT flags;

	always_comb begin
		// Subtract as A + ~B + 1
		addB   = (aluOp == legv8Pkg::opSub) ? ~opB : opB;
		addCin = (aluOp == legv8Pkg::opSub) ? 1'b1 : carryIn;
		sum    = {1'b0, opA} + {1'b0, addB} + {64'd0, addCin};
		flags  = '0;
		case (aluOp)
			legv8Pkg::opAnd:   aluOut = opA & opB;
			legv8Pkg::opOr:    aluOut = opA | opB;
			legv8Pkg::opXor:   aluOut = opA ^ opB;
			legv8Pkg::opAdd,
			legv8Pkg::opSub: begin
				aluOut  = sum[63:0];
				flags.c = sum[64];
				// Same-sign operands, result sign flipped
				flags.v = (opA[63] == addB[63]) && (sum[63] != opA[63]);
			end
			// Shift amount is the low 6 bits
			legv8Pkg::opLsl:   aluOut = opA << opB[5:0];
			legv8Pkg::opLsr:   aluOut = opA >> opB[5:0];
			legv8Pkg::opPassB: aluOut = opB;
			default:           aluOut = '0;
		endcase
		flags.n = aluOut[63];
		flags.z = (aluOut == '0);
	end

	// Single entry, moves when memory stage can take it
	assign upReady = !exValid || downReady;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			exValid <= 1'b0;
		end else if (upReady) begin
			exValid <= decValid;
		end
	end

	always_ff @(posedge clock) begin
		if (upReady && decValid) begin
			aluResult   <= aluOut;
			aluStatus   <= flags;
			exStoreData <= storeData;
			exDestReg   <= destReg;
			exRegWrite  <= regWrite;
			exMemEnable <= memEnable;
			exMemWrite  <= memWrite;
			exMemSize   <= memSize;
		end
	end

endmodule

`default_nettype wire

// ==== src/legv8Pkg.sv ====
`default_nettype none

package legv8Pkg;

	// Register 31 reads as zero
	localparam logic [4:0] zeroReg = 5'd31;

	// Control word field positions
	localparam int daLo     = 0;
	localparam int saLo     = 5;
	localparam int sbLo     = 10;
	localparam int regWrBit = 15;
	localparam int bselBit  = 16;
	localparam int fsLo     = 17;
	localparam int c0Bit    = 22;
	localparam int memEnBit = 23;
	localparam int memWrBit = 24;
	localparam int sizeLo   = 25;
	// Bits 31:27 unused

	// ALU function select, FS field
	typedef enum logic [4:0] {
		opAnd   = 5'd0,
		opOr    = 5'd1,
		opXor   = 5'd2,
		opAdd   = 5'd3,
		opSub   = 5'd4,
		opLsl   = 5'd5,
		opLsr   = 5'd6,
		opPassB = 5'd7
	} aluOpE;

	// Transfer size, bytes = 1 << size
	typedef enum logic [1:0] {
		size8  = 2'd0,
		size16 = 2'd1,
		size32 = 2'd2,
		size64 = 2'd3
	} memSizeE;

	// Status bits, V at the top
	typedef struct packed {
		logic v;
		logic c;
		logic n;
		logic z;
	} statusT;

endpackage

`default_nettype wire

// ==== src/memAccessStage.sv ====
`default_nettype none

module memAccessStage #(
	parameter int memDepthBytes = 256
) (
	input  wire logic              clock,
	input  wire logic              arstN,
	input  wire logic              exValid,
	input  wire logic [4:0]        exDestReg,
	input  wire logic              exRegWrite,
	input  wire logic [63:0]       aluResult,
	input  wire legv8Pkg::statusT  aluStatus,
	input  wire logic [63:0]       exStoreData,
	input  wire logic              exMemEnable,
	input  wire logic              exMemWrite,
	input  wire legv8Pkg::memSizeE exMemSize,
	input  wire logic              resultReady,
	output logic                   upReady,
	output logic                   resultValid,
	output logic [63:0]            result,
	output legv8Pkg::statusT       status,
	output logic                   memValid,
	output logic [4:0]             memDestReg,
	output logic                   memRegWrite,
	output logic                   writeEn,
	output logic [4:0]             writeAddr,
	output logic [63:0]            writeData
);

	logic [63:0]       heldAlu;
	logic              heldMemEn;
	logic              heldMemWr;
	legv8Pkg::memSizeE heldSize;
	logic              storeEn;
	logic [63:0]       loadData;

	assign upReady = !memValid || resultReady;

	// Store commits on the edge that loads this entry
	assign storeEn = upReady && exValid && exMemEnable && exMemWrite;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			memValid <= 1'b0;
		end else if (upReady) begin
			memValid <= exValid;
		end
	end

	always_ff @(posedge clock) begin
		if (upReady && exValid) begin
			heldAlu     <= aluResult;
			status      <= aluStatus;
			memDestReg  <= exDestReg;
			memRegWrite <= exRegWrite;
			heldMemEn   <= exMemEnable;
			heldMemWr   <= exMemWrite;
			heldSize    <= exMemSize;
		end
	end

	// Load address comes from the held entry
	dataMemory #(
		.memDepthBytes(memDepthBytes)
	) u_dataMemory (
		.clock    (clock),
		.arstN    (arstN),
		.writeEn  (storeEn),
		.writeAddr(aluResult),
		.writeSize(exMemSize),
		.writeData(exStoreData),
		.readAddr (heldAlu),
		.readSize (heldSize),
		.readData (loadData)
	);

	assign resultValid = memValid;
	// Loaded data for reads, otherwise ALU value (address for stores)
	assign result      = (heldMemEn && !heldMemWr) ? loadData : heldAlu;

	// Write-back when the result is consumed
	assign writeEn   = memValid && resultReady && memRegWrite
		&& (memDestReg != legv8Pkg::zeroReg);
	assign writeAddr = memDestReg;
	assign writeData = result;

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
`default_nettype none

module registerFile (
	input  wire logic        clock,
	input  wire logic        arstN,
	input  wire logic [4:0]  readAddrA,
	input  wire logic [4:0]  readAddrB,
	input  wire logic        writeEn,
	input  wire logic [4:0]  writeAddr,
	input  wire logic [63:0] writeData,
	output logic      [63:0] readDataA,
	output logic      [63:0] readDataB
);

	logic [63:0] regs [32];

	// Entry 31 is never written, so it stays at its reset value
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != legv8Pkg::zeroReg)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Combinational reads
	// Old value on a same-cycle write
	assign readDataA = (readAddrA == legv8Pkg::zeroReg) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == legv8Pkg::zeroReg) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// ==== testbench/datapathStim.txt ====
// group  controlWord  constant  expectedResult  expectedStatus(VCNZ)
// groups: 1 regs, 2 arith, 3 logic/shift, 4 memory, 5 dependent chain, 6 mixed
1 000FFFE1 0123456789ABCDEF 0123456789ABCDEF 0
1 000FFFE2 8000000000000001 8000000000000001 2
1 000FFFFF 00000000DEADBEEF 00000000DEADBEEF 0
1 0002FC23 0000000000000000 0123456789ABCDEF 0
1 0002FFE4 0000000000000000 0000000000000000 1
2 0007FC25 0000000000000001 0123456789ABCDF0 0
2 0047FC26 0000000000000001 0123456789ABCDF1 0
2 0009FC27 0123456789ABCDEF 0000000000000000 5
2 0007FC48 FFFFFFFFFFFFFFFF 8000000000000000 6
2 0007FC29 7FFFFFFFFFFFFFFF 8123456789ABCDEE A
3 0001FC2A 00000000FFFF0000 0000000089AB0000 0
3 0004842B 0000000000000000 0000000000000000 1
3 000BFC4C 0000000000000000 8000000000000001 2
3 000DFC4D 000000000000003F 0000000000000001 0
3 000BFC2E 0000000000000044 123456789ABCDEF0 0
4 078707FF 0000000000000010 0000000000000010 0
4 01870BFF 0000000000000012 0000000000000012 0
4 03870BFF 0000000000000015 0000000000000015 0
4 058707FF 000000000000001B 000000000000001B 0
4 0687FFEF 0000000000000010 012300018901CDEF 0
4 0287FFF0 0000000000000013 0000000000008901 0
4 0487FFF1 000000000000001A 0000000089ABCDEF 0
4 0087FFF2 0000000000000016 0000000000000023 0
5 0007FC34 0000000000000001 0123456789ABCDF0 0
5 0006D294 0000000000000000 02468ACF13579BE0 0
5 00088695 0000000000000000 0123456789ABCDF1 4
5 000DFEB6 0000000000000004 00123456789ABCDF 0
6 0003FC39 00000000000000F0 0123456789ABCDFF 0
6 0009FFFB 0000000000000001 FFFFFFFFFFFFFFFF 2
6 0000845A 0000000000000000 0000000000000001 0

// ==== testbench/datapathTb.sv ====
`default_nettype none

module datapathTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clkPeriod = 40;
	localparam int maxOps    = 64;
	// Words per stim line: group, control word, constant, result, status
	localparam int lineWords = 5;

	logic             clock;
	logic             arstN;
	logic             cwValid;
	logic             cwReady;
	logic [31:0]      controlWord;
	logic [63:0]      constant;
	logic             resultValid;
	logic             resultReady;
	logic [63:0]      result;
	legv8Pkg::statusT status;

	// Raw stim words, unread entries stay X or zero
	logic [63:0]      stimWords [maxOps*lineWords];
	int               groupId [maxOps];
	logic [31:0]      cwList [maxOps];
	logic [63:0]      constList [maxOps];
	logic [63:0]      expResult [maxOps];
	legv8Pkg::statusT expStatus [maxOps];
	int               numOps;
	int               passCount;
	int               failCount;
	int unsigned      prodSeed;
	int unsigned      consSeed;

	datapathWithMemory #(
		.memDepthBytes(256)
	) u_datapathWithMemory (
		.clock      (clock),
		.arstN      (arstN),
		.cwValid    (cwValid),
		.cwReady    (cwReady),
		.controlWord(controlWord),
		.constant   (constant),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.result     (result),
		.status     (status)
	);

	initial begin
		clock = 1'b0;
		forever #(clkPeriod / 2) clock = ~clock;
	end

	// LCG state update, callers use the upper bits
	function automatic int unsigned lcgStep(input int unsigned seed);
		return seed * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic loadStim();
		int base;
		$readmemh("testbench/datapathStim.txt", stimWords);
		numOps = 0;
		// Stop at the first group word left unknown or zero
		while (numOps < maxOps && !$isunknown(stimWords[numOps*lineWords])
			&& stimWords[numOps*lineWords] != '0) begin
			base               = numOps * lineWords;
			groupId[numOps]    = int'(stimWords[base]);
			cwList[numOps]     = stimWords[base+1][31:0];
			constList[numOps]  = stimWords[base+2];
			expResult[numOps]  = stimWords[base+3];
			expStatus[numOps]  = stimWords[base+4][3:0];
			numOps++;
		end
	endtask

	task automatic checkResult(input int idx, input logic [63:0] got, input logic [63:0] exp);
		if (got === exp) begin
			passCount++;
		end else begin
			failCount++;
			$display("error %0t: op %0d result %h, expected %h", $time, idx, got, exp);
		end
	endtask

	task automatic checkStatus(input int idx, input legv8Pkg::statusT got,
		input legv8Pkg::statusT exp);
		if (got === exp) begin
			passCount++;
		end else begin
			failCount++;
			$display("error %0t: op %0d status VCNZ %b, expected %b", $time, idx, got, exp);
		end
	endtask

	// Producer, one word at a time with random idle gaps
	task automatic driveWords();
		int   gap;
		logic taken;
		for (int i = 0; i < numOps; i++) begin
			prodSeed = lcgStep(prodSeed);
			gap      = int'((prodSeed >> 16) % 3);
			repeat (gap) @(negedge clock);
			cwValid     = 1'b1;
			controlWord = cwList[i];
			constant    = constList[i];
			taken       = 1'b0;
			// Sample ready mid low phase, word taken on the next rising edge
			while (!taken) begin
				#(clkPeriod / 4);
				taken = cwReady;
				@(negedge clock);
			end
			cwValid = 1'b0;
		end
	endtask

	// Consumer with random back-pressure, checks in acceptance order
	task automatic collectResults();
		int got;
		int groupStart;
		int groupFails;
		got        = 0;
		groupStart = 0;
		groupFails = failCount;
		while (got < numOps) begin
			@(negedge clock);
			consSeed    = lcgStep(consSeed);
			resultReady = ((consSeed >> 16) % 4) != 0;
			// Consumed on the next rising edge
			if (resultValid && resultReady) begin
				checkResult(got, result, expResult[got]);
				checkStatus(got, status, expStatus[got]);
				got++;
				if (got == numOps || groupId[got] != groupId[got-1]) begin
					$display("group %0d done: %0d ops, %0d errors", groupId[got-1],
						got - groupStart, failCount - groupFails);
					groupStart = got;
					groupFails = failCount;
				end
			end
		end
		resultReady = 1'b0;
	endtask

	initial begin
		arstN       = 1'b0;
		cwValid     = 1'b0;
		controlWord = '0;
		constant    = '0;
		resultReady = 1'b0;
		passCount   = 0;
		failCount   = 0;
		prodSeed    = 32'd32919;
		// Consumer runs one step ahead of the producer
		consSeed    = lcgStep(prodSeed);
		loadStim();
		if (numOps == 0) begin
			failCount++;
			$display("the stim file gave no operations to run");
		end
		repeat (4) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
		fork
			driveWords();
			collectResults();
		join
		$display("%0d checks passed, %0d failed", passCount, failCount);
		if (failCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Watchdog, budget scales with the number of operations
	initial begin
		@(posedge arstN);
		#(clkPeriod * (numOps * 12 + 50));
		$display("timeout: results missing");
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
